// File: rtl/smc_access_fsm.sv
//--------------------------------------------------------------------------
// Access sequencer
// Works out how many narrow accesses a transfer needs, counts
// them down and steps the FSM idle, read/write, done
//--------------------------------------------------------------------------
`default_nettype none

module smc_access_fsm
   import smc_lite_pkg::*;
(
   input  logic       sys_clk15,
   input  logic       n_sys_reset15,
   input  logic       valid_access,    // Start of new transfer
   input  logic [1:0] xfer_size,       // Live transfer size
   input  logic [1:0] r_xfer_size,     // Stored transfer size
   input  logic [1:0] bus_size,        // External bus width strap
   output logic [1:0] smc_nextstate,   // Next state
   output logic [1:0] r_num_access,    // Remaining accesses after this one
   output logic [1:0] v_xfer_size,     // Validated transfer size
   output logic       smc_done         // High in st_done
);

   logic [1:0] smc_state;    // Current state
   logic [1:0] num_acc_m1;   // Access count of the transfer, minus one

   // Live field on the capture cycle, stored copy afterwards
   assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

   // Accesses needed for this transfer on this bus
   always_comb
   begin
      case ({v_xfer_size, bus_size})
         {xsiz_32, bsiz_16} : num_acc_m1 = 2'd1;   // Two halfwords
         {xsiz_32, bsiz_8}  : num_acc_m1 = 2'd3;   // Four bytes
         {xsiz_16, bsiz_8}  : num_acc_m1 = 2'd1;   // Two bytes
         default            : num_acc_m1 = 2'd0;   // Fits in one access
      endcase
   end

   //-----------------------------------------------------------------------
   // Next state decode
   //-----------------------------------------------------------------------
   always_comb
   begin
      case (smc_state)
         st_idle :
            smc_nextstate = valid_access ? st_rw : st_idle;
         st_rw :
            smc_nextstate = (r_num_access == 2'd0) ? st_done : st_rw;
         st_done :
            smc_nextstate = st_idle;   // One cycle only
         default :
            smc_nextstate = st_idle;
      endcase
   end

   // State register and access counter
   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
      begin
         smc_state    <= st_idle;
         r_num_access <= 2'd0;
      end
      else
      begin
         smc_state <= smc_nextstate;

         if (valid_access)
            r_num_access <= num_acc_m1;               // Load on capture
         else if ((smc_state == st_rw) && (r_num_access != 2'd0))
            r_num_access <= r_num_access - 2'd1;      // One per access
      end
   end

   assign smc_done = (smc_state == st_done);

endmodule

`default_nettype wire

// File: rtl/smc_addr_gen.sv
//--------------------------------------------------------------------------
// External address, byte enable and chip select generation
// First access from the host address, later ones from the count,
// little-endian, descending; output stage aligns with the data path
//--------------------------------------------------------------------------
`default_nettype none

module smc_addr_gen
   import smc_lite_pkg::*;
(
   input  logic        sys_clk15,
   input  logic        n_sys_reset15,
   input  logic        valid_access,    // Start of new transfer
   input  logic [1:0]  r_num_access,    // Remaining access count
   input  logic [1:0]  bus_size,        // External bus width strap
   input  logic [1:0]  v_xfer_size,     // Validated transfer size
   input  logic        cs,              // Chip select, live address
   input  logic [31:0] addr,            // Live host address
   input  logic [1:0]  smc_nextstate,   // Next FSM state
   output logic [31:0] smc_addr,        // External address pins
   output logic [3:0]  smc_n_be,        // External byte enables
   output logic        smc_n_cs,        // External chip select
   output logic [1:0]  smc_addr_low     // Low bits of current access
);

   logic        r_cs;       // Stored chip select
   logic [1:0]  r_addr;     // Stored low address bits
   logic        v_cs;       // Validated chip select
   logic [1:0]  v_addr;     // Validated low address bits
   logic [3:0]  n_be;       // Internal byte enables
   logic [31:0] acc_addr;   // Address of current access
   logic [3:0]  acc_n_be;   // Byte enables of current access
   logic        acc_n_cs;   // Chip select of current access

   //-----------------------------------------------------------------------
   // Stored and validated chip select and low address bits
   //-----------------------------------------------------------------------
   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
      begin
         r_cs   <= 1'b0;
         r_addr <= 2'b00;
      end
      else if (valid_access)
      begin
         r_cs   <= cs;
         r_addr <= addr[1:0];
      end
   end

   assign v_cs   = valid_access ? cs : r_cs;
   assign v_addr = valid_access ? addr[1:0] : r_addr;

   //-----------------------------------------------------------------------
   // Access address
   //-----------------------------------------------------------------------
   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
         acc_addr <= 32'h0;
      else if (valid_access)
      begin
         acc_addr[31:2] <= addr[31:2];     // Upper bits fixed per transfer
         case ({v_xfer_size, bus_size})
            {xsiz_32, bsiz_32} : acc_addr[1:0] <= 2'b00;
            {xsiz_32, bsiz_16} : acc_addr[1:0] <= 2'b10;   // Upper half first
            {xsiz_32, bsiz_8}  : acc_addr[1:0] <= 2'b11;   // Top byte first
            {xsiz_16, bsiz_32},
            {xsiz_16, bsiz_16} : acc_addr[1:0] <= {addr[1], 1'b0};
            {xsiz_16, bsiz_8}  : acc_addr[1:0] <= {addr[1], 1'b1};
            default            : acc_addr[1:0] <= addr[1:0];   // Byte
         endcase
      end
      else if (smc_nextstate == st_rw)
      begin
         // Later accesses step down with the count
         case ({v_xfer_size, bus_size})
            {xsiz_32, bsiz_16} : acc_addr[1:0] <= 2'b00;
            {xsiz_32, bsiz_8}  : acc_addr[1:0] <= r_num_access - 2'd1;
            {xsiz_16, bsiz_8}  : acc_addr[1:0] <= {r_addr[1], 1'b0};
            default            : acc_addr[1:0] <= acc_addr[1:0];
         endcase
      end
   end

   assign smc_addr_low = acc_addr[1:0];   // Lane select for data path

   //-----------------------------------------------------------------------
   // Internal byte enables, active low
   //-----------------------------------------------------------------------
   always_comb
   begin
      if (v_cs)
      begin
         casez ({v_xfer_size, bus_size, v_addr})
            {xsiz_8,  bsiz_8,  2'b??} : n_be = 4'b1110;   // Lane 0 only
            {xsiz_8,  bsiz_16, 2'b?0} : n_be = 4'b1110;
            {xsiz_8,  bsiz_16, 2'b?1} : n_be = 4'b1101;
            {xsiz_8,  bsiz_32, 2'b00} : n_be = 4'b1110;
            {xsiz_8,  bsiz_32, 2'b01} : n_be = 4'b1101;
            {xsiz_8,  bsiz_32, 2'b10} : n_be = 4'b1011;
            {xsiz_8,  bsiz_32, 2'b11} : n_be = 4'b0111;
            {xsiz_16, bsiz_8,  2'b??} : n_be = 4'b1110;
            {xsiz_16, bsiz_16, 2'b??} : n_be = 4'b1100;   // Lanes 1 and 0
            {xsiz_16, bsiz_32, 2'b0?} : n_be = 4'b1100;
            {xsiz_16, bsiz_32, 2'b1?} : n_be = 4'b0011;
            {xsiz_32, bsiz_8,  2'b??} : n_be = 4'b1110;
            {xsiz_32, bsiz_16, 2'b??} : n_be = 4'b1100;
            {xsiz_32, bsiz_32, 2'b??} : n_be = 4'b0000;   // Full word
            default                   : n_be = 4'b1111;   // Illegal size
         endcase
      end
      else
         n_be = 4'b1111;   // Outside window
   end

   // Access controls, active only while next state is st_rw
   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
      begin
         acc_n_be <= 4'hf;
         acc_n_cs <= 1'b1;
      end
      else if (smc_nextstate == st_rw)
      begin
         acc_n_be <= n_be;
         acc_n_cs <= ~v_cs;
      end
      else
      begin
         acc_n_be <= 4'hf;
         acc_n_cs <= 1'b1;
      end
   end

   //-----------------------------------------------------------------------
   // Output stage, one cycle behind to meet the steered data
   //-----------------------------------------------------------------------
   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
      begin
         smc_addr <= 32'h0;
         smc_n_be <= 4'hf;
         smc_n_cs <= 1'b1;
      end
      else
      begin
         smc_addr <= acc_addr;
         smc_n_be <= acc_n_be;
         smc_n_cs <= acc_n_cs;
      end
   end

endmodule

`default_nettype wire

// File: rtl/smc_host_port.sv
//--------------------------------------------------------------------------
// Host side of the controller
// Four-phase req/ack slave, captures one write transfer,
// decodes the chip select from the address window
//--------------------------------------------------------------------------
`default_nettype none

module smc_host_port
   import smc_lite_pkg::*;
(
   input  logic        sys_clk15,
   input  logic        n_sys_reset15,
   input  logic        req,            // Host request
   input  logic [31:0] addr,           // Host address
   input  logic [1:0]  xfer_size,      // Host transfer size
   input  logic [31:0] wdata,          // Host write word
   input  logic        smc_done,       // Last access finished
   output logic        ack,            // Host acknowledge
   output logic        valid_access,   // Start of new transfer
   output logic        cs,             // Chip select, live address
   output logic [1:0]  r_xfer_size,    // Stored transfer size
   output logic [31:0] r_wdata         // Stored write word
);

   logic busy;   // Transfer in progress until req and ack both low

   // New transfer only on a req seen while not busy
   assign valid_access = req & ~busy;

   // Window compare on live address
   assign cs = (addr[31:28] == cs_base);

   //-----------------------------------------------------------------------
   // Handshake control
   //-----------------------------------------------------------------------
   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
      begin
         ack  <= 1'b0;
         busy <= 1'b0;
      end
      else
      begin
         if (smc_done)
            ack <= 1'b1;           // Held until host drops req
         else if (!req)
            ack <= 1'b0;

         if (valid_access)
            busy <= 1'b1;
         else if (!req && !ack)
            busy <= 1'b0;          // Four-phase cycle complete
      end
   end

   // Field capture for later accesses
   always_ff @(posedge sys_clk15)
   begin
      if (valid_access)
      begin
         r_xfer_size <= xfer_size;
         r_wdata     <= wdata;
      end
   end

endmodule

`default_nettype wire

// File: rtl/smc_lite_pkg.sv
//--------------------------------------------------------------------------
// Shared encodings of the static memory controller
// Transfer size and external bus size codes, FSM state codes,
// chip-select address window and the host write-word union
//--------------------------------------------------------------------------
`default_nettype none

package smc_lite_pkg;

   // Host transfer size, fourth code illegal
   localparam logic [1:0] xsiz_8  = 2'b00;     // Byte
   localparam logic [1:0] xsiz_16 = 2'b01;     // Halfword
   localparam logic [1:0] xsiz_32 = 2'b10;     // Word

   // External data bus width strap
   localparam logic [1:0] bsiz_8  = 2'b00;
   localparam logic [1:0] bsiz_16 = 2'b01;
   localparam logic [1:0] bsiz_32 = 2'b10;

   // Access FSM states
   localparam logic [1:0] st_idle = 2'b00;     // Waiting for valid_access
   localparam logic [1:0] st_rw   = 2'b01;     // One external access per cycle
   localparam logic [1:0] st_done = 2'b10;     // Transfer finished

   // Chip select window, compared with addr[31:28]
   localparam logic [3:0] cs_base = 4'h8;

   // Host write word, seen as bytes or as halfwords
   typedef union packed {
      logic [3:0][7:0]  bytes;
      logic [1:0][15:0] halves;
   } smc_word_u;

endpackage

`default_nettype wire

// File: rtl/smc_lite_top.sv
//--------------------------------------------------------------------------
// Top level of the static memory controller
// Host port, access FSM, address generator and memory port
//--------------------------------------------------------------------------
`default_nettype none

module smc_lite_top (
   input  logic        sys_clk15,
   input  logic        n_sys_reset15,
   input  logic        req,         // Host request
   output logic        ack,         // Host acknowledge
   input  logic [31:0] addr,        // Host address
   input  logic [1:0]  xfer_size,   // Host transfer size
   input  logic [31:0] wdata,       // Host write word
   input  logic [1:0]  bus_size,    // External bus width strap
   output logic [31:0] smc_addr,
   output logic [3:0]  smc_n_be,
   output logic        smc_n_cs,
   output logic        smc_n_we,
   output logic [31:0] smc_data
);

   // Internal connections
   logic        valid_access;
   logic        cs;
   logic [1:0]  r_xfer_size;
   logic [31:0] r_wdata;
   logic        smc_done;
   logic [1:0]  smc_nextstate;
   logic [1:0]  r_num_access;
   logic [1:0]  v_xfer_size;
   logic [1:0]  smc_addr_low;

   smc_host_port smc_host_port_inst (
      .sys_clk15    (sys_clk15),
      .n_sys_reset15(n_sys_reset15),
      .req          (req),
      .addr         (addr),
      .xfer_size    (xfer_size),
      .wdata        (wdata),
      .smc_done     (smc_done),
      .ack          (ack),
      .valid_access (valid_access),
      .cs           (cs),
      .r_xfer_size  (r_xfer_size),
      .r_wdata      (r_wdata)
   );

   smc_access_fsm smc_access_fsm_inst (
      .sys_clk15    (sys_clk15),
      .n_sys_reset15(n_sys_reset15),
      .valid_access (valid_access),
      .xfer_size    (xfer_size),
      .r_xfer_size  (r_xfer_size),
      .bus_size     (bus_size),
      .smc_nextstate(smc_nextstate),
      .r_num_access (r_num_access),
      .v_xfer_size  (v_xfer_size),
      .smc_done     (smc_done)
   );

   smc_addr_gen smc_addr_gen_inst (
      .sys_clk15    (sys_clk15),
      .n_sys_reset15(n_sys_reset15),
      .valid_access (valid_access),
      .r_num_access (r_num_access),
      .bus_size     (bus_size),
      .v_xfer_size  (v_xfer_size),
      .cs           (cs),
      .addr         (addr),
      .smc_nextstate(smc_nextstate),
      .smc_addr     (smc_addr),
      .smc_n_be     (smc_n_be),
      .smc_n_cs     (smc_n_cs),
      .smc_addr_low (smc_addr_low)
   );

   smc_mem_port smc_mem_port_inst (
      .sys_clk15    (sys_clk15),
      .n_sys_reset15(n_sys_reset15),
      .smc_nextstate(smc_nextstate),
      .bus_size     (bus_size),
      .r_wdata      (r_wdata),
      .smc_addr_low (smc_addr_low),
      .smc_data     (smc_data),
      .smc_n_we     (smc_n_we)
   );

endmodule

`default_nettype wire

// File: rtl/smc_mem_port.sv
//--------------------------------------------------------------------------
// Memory side data path
// Steers the selected byte or halfword onto the external lanes
// and drives the write strobe, aligned with the address pins
//--------------------------------------------------------------------------
`default_nettype none

module smc_mem_port
   import smc_lite_pkg::*;
(
   input  logic        sys_clk15,
   input  logic        n_sys_reset15,
   input  logic [1:0]  smc_nextstate,   // Next FSM state
   input  logic [1:0]  bus_size,        // External bus width strap
   input  logic [31:0] r_wdata,         // Stored write word
   input  logic [1:0]  smc_addr_low,    // Low bits of current access
   output logic [31:0] smc_data,        // External data lanes
   output logic        smc_n_we         // External write strobe
);

   smc_word_u   word;        // Write word, byte or halfword view
   logic [31:0] lane_data;   // Steered data of current access
   logic        n_we_q;      // Strobe of current access

   assign word = r_wdata;

   // Lane steering, unused upper lanes zero
   always_comb
   begin
      case (bus_size)
         bsiz_32 : lane_data = word;
         bsiz_16 : lane_data = {16'h0, word.halves[smc_addr_low[1]]};
         bsiz_8  : lane_data = {24'h0, word.bytes[smc_addr_low]};
         default : lane_data = 32'h0;
      endcase
   end

   // Strobe follows the access, then the output stage
   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
      begin
         n_we_q   <= 1'b1;
         smc_n_we <= 1'b1;
      end
      else
      begin
         n_we_q   <= (smc_nextstate != st_rw);
         smc_n_we <= n_we_q;
      end
   end

   always_ff @(posedge sys_clk15)
      smc_data <= lane_data;   // Lines up with smc_n_we

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the smc_lite simulation with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module smc_lite_tb \
   -f smc_lite.f -Mdir obj_dir -o smc_lite_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/smc_lite_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log_file"; then
   exit 0
fi
echo "Pass message not found in $log_file"
exit 1

// File: smc_lite.f
rtl/smc_lite_pkg.sv
rtl/smc_host_port.sv
rtl/smc_access_fsm.sv
rtl/smc_addr_gen.sv
rtl/smc_mem_port.sv
rtl/smc_lite_top.sv
verif/smc_lite_assert.sv
verif/smc_lite_tb.sv

// File: verif/smc_lite_assert.sv
//--------------------------------------------------------------------------
// Protocol assertions on the controller top level
// Handshake order, chip select with write strobe, legal transfer size
//--------------------------------------------------------------------------
`default_nettype none

module smc_lite_assert
   import smc_lite_pkg::*;
(
   input logic       sys_clk15,
   input logic       n_sys_reset15,
   input logic       req,
   input logic       ack,
   input logic [1:0] xfer_size,
   input logic       smc_n_cs,
   input logic       smc_n_we
);

   timeunit 1ns;
   timeprecision 100ps;

   // ack only answers a pending request
   ack_needs_req : assert property (@(posedge sys_clk15) disable iff (!n_sys_reset15)
      $rose(ack) |-> req)
      else $error("ack rose while req was low");

   // Selected cycles are always write cycles
   cs_with_we : assert property (@(posedge sys_clk15) disable iff (!n_sys_reset15)
      !smc_n_cs |-> !smc_n_we)
      else $error("smc_n_cs low without smc_n_we low");

   legal_size : assert property (@(posedge sys_clk15) disable iff (!n_sys_reset15)
      req |-> ((xfer_size == xsiz_8) || (xfer_size == xsiz_16) || (xfer_size == xsiz_32)))
      else $error("illegal xfer_size during req");   // Fourth code

endmodule

bind smc_lite_top smc_lite_assert smc_lite_assert_inst (
   .sys_clk15    (sys_clk15),
   .n_sys_reset15(n_sys_reset15),
   .req          (req),
   .ack          (ack),
   .xfer_size    (xfer_size),
   .smc_n_cs     (smc_n_cs),
   .smc_n_we     (smc_n_we)
);

`default_nettype wire

// File: verif/smc_lite_tb.sv
//--------------------------------------------------------------------------
// Testbench of the static memory controller
// Clock, reset, req/ack stimulus, reference access model,
// pin monitor, access compare and watchdog
//--------------------------------------------------------------------------
`default_nettype none

module smc_lite_tb
   import smc_lite_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int n_xfers    = 225;   // 25 directed, 200 random
   localparam int xfer_limit = 12;    // Cycles allowed per transfer
   localparam int rst_cycles = 8;

   logic        sys_clk15 = 1'b0;
   logic        n_sys_reset15;
   logic        req;
   logic        ack;
   logic [31:0] addr;
   logic [1:0]  xfer_size;
   logic [31:0] wdata;
   logic [1:0]  bus_size;
   logic [31:0] smc_addr;
   logic [3:0]  smc_n_be;
   logic        smc_n_cs;
   logic        smc_n_we;
   logic [31:0] smc_data;

   logic [68:0] exp_q[$];        // {n_cs, n_be, addr, data}
   logic [68:0] act_q[$];        // Same layout, from the pins
   int          acc_count = 0;   // Write strobe cycles seen
   int          cs_count = 0;    // Chip select cycles seen
   int          access_errors = 0;
   int          xfer_errors = 0;
   int          proto_errors = 0;
   string       test_name = "reset_idle";

   smc_lite_top smc_lite_top_inst (.*);

   always #2 sys_clk15 = ~sys_clk15;   // 4 ns period

   // Mismatch report, returns 1 on error
   function automatic int check_value(input string what, input logic [31:0] want,
                                      input logic [31:0] got);
      if (want != got)
      begin
         $display("** Error [%s] %s: expected %h, actual %h", test_name, what, want, got);
         return 1;
      end
      return 0;
   endfunction

   //-----------------------------------------------------------------------
   // Reference model, expands one transfer into its external accesses
   //-----------------------------------------------------------------------
   function automatic int expand_transfer(input logic [31:0] a, input logic [1:0] sz,
                                          input logic [1:0] bs, input logic [31:0] d);
      smc_word_u   w;
      logic        sel;
      logic [1:0]  idx;
      logic [1:0]  lo;
      logic [3:0]  be;
      logic [31:0] lane;
      int          n;
      int          i;
      w   = d;
      sel = (a[31:28] == cs_base);                     // Address window
      if (sz == xsiz_32)
         n = (bs == bsiz_32) ? 1 : ((bs == bsiz_16) ? 2 : 4);
      else if (sz == xsiz_16)
         n = (bs == bsiz_8) ? 2 : 1;
      else
         n = 1;                                        // Byte always fits
      for (i = 0; i < n; i++)
      begin
         idx = i[1:0];
         // Low address, descending order
         if ((sz == xsiz_32) && (bs == bsiz_8))
            lo = 2'd3 - idx;
         else if ((sz == xsiz_32) && (bs == bsiz_16))
            lo = (idx == 2'd0) ? 2'b10 : 2'b00;
         else if (sz == xsiz_32)
            lo = 2'b00;
         else if ((sz == xsiz_16) && (bs == bsiz_8))
            lo = {a[1], ~idx[0]};
         else if (sz == xsiz_16)
            lo = {a[1], 1'b0};
         else
            lo = a[1:0];
         // Byte enables, active low
         if (!sel)
            be = 4'b1111;                              // Not selected
         else if (bs == bsiz_8)
            be = 4'b1110;
         else if (bs == bsiz_16)
            be = (sz != xsiz_8) ? 4'b1100 : (a[0] ? 4'b1101 : 4'b1110);
         else if (sz == xsiz_8)
            be = ~(4'b0001 << a[1:0]);                 // One lane low
         else if (sz == xsiz_16)
            be = a[1] ? 4'b0011 : 4'b1100;
         else
            be = 4'b0000;
         // Lane steering, upper lanes zero
         if (bs == bsiz_32)
            lane = d;
         else if (bs == bsiz_16)
            lane = {16'h0, w.halves[lo[1]]};
         else
            lane = {24'h0, w.bytes[lo]};
         exp_q.push_back({~sel, be, a[31:2], lo, lane});
      end
      return n;
   endfunction

   task automatic set_bus(input logic [1:0] bs);
      @(posedge sys_clk15);
      bus_size <= bs;                                  // Only while idle
   endtask

   // One four-phase write transfer
   task automatic run_transfer(input logic [31:0] a, input logic [1:0] sz,
                               input logic [31:0] d);
      int n_exp;
      int acc_start;
      int cs_start;
      int t;
      @(posedge sys_clk15);
      n_exp     = expand_transfer(a, sz, bus_size, d);
      acc_start = acc_count;
      cs_start  = cs_count;
      addr      <= a;
      xfer_size <= sz;
      wdata     <= d;
      req       <= 1'b1;
      t = 0;
      while (!ack && (t < 20))
      begin
         @(negedge sys_clk15);
         t++;
      end
      if (!ack)
      begin
         $display("ack did not rise within 20 cycles in test %s", test_name);
         proto_errors++;
         exp_q.delete();                               // Resync the compare
      end
      else if ((acc_count - acc_start) != n_exp)
      begin
         $display("** Error [%s] access count: expected %0d, actual %0d",
                  test_name, n_exp, acc_count - acc_start);
         xfer_errors++;
      end
      if ((a[31:28] != cs_base) && (cs_count != cs_start))
      begin
         $display("smc_n_cs went low for address %h outside the window", a);
         proto_errors++;
      end
      @(posedge sys_clk15);
      req <= 1'b0;
      t = 0;
      while (ack && (t < 20))
      begin
         @(negedge sys_clk15);
         t++;
      end
      if (ack)
      begin
         $display("ack stayed high after req was dropped in test %s", test_name);
         proto_errors++;
      end
   endtask

   //-----------------------------------------------------------------------
   // Pin monitor and compare
   //-----------------------------------------------------------------------
   always @(negedge sys_clk15)
   begin
      if (n_sys_reset15 && !smc_n_we)
      begin
         act_q.push_back({smc_n_cs, smc_n_be, smc_addr, smc_data});
         acc_count++;
      end
      if (n_sys_reset15 && !smc_n_cs)
         cs_count++;
   end

   always @(posedge sys_clk15)
   begin
      logic [68:0] act_acc;
      logic [68:0] exp_acc;
      while (act_q.size() != 0)
      begin
         act_acc = act_q.pop_front();
         if (exp_q.size() == 0)
         begin
            $display("Unexpected access at address %h in test %s", act_acc[63:32], test_name);
            access_errors++;
         end
         else
         begin
            exp_acc = exp_q.pop_front();
            access_errors += check_value("smc_n_cs", 32'(exp_acc[68]), 32'(act_acc[68]));
            access_errors += check_value("smc_n_be", 32'(exp_acc[67:64]),
                                         32'(act_acc[67:64]));
            access_errors += check_value("smc_addr", exp_acc[63:32], act_acc[63:32]);
            access_errors += check_value("smc_data", exp_acc[31:0], act_acc[31:0]);
         end
      end
   end

   // Watchdog
   initial
   begin
      repeat (n_xfers * xfer_limit + rst_cycles) @(posedge sys_clk15);
      $display("Watchdog expired before all transfers finished");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   //-----------------------------------------------------------------------
   // Stimulus
   //-----------------------------------------------------------------------
   initial
   begin
      int          b;
      int          lo;
      int          k;
      logic [31:0] r;
      logic [31:0] ra;
      void'($urandom(32'hf9f1_f70a));
      n_sys_reset15 = 1'b0;
      req           = 1'b0;
      addr          = 32'h0;
      xfer_size     = xsiz_8;
      wdata         = 32'h0;
      bus_size      = bsiz_32;
      repeat (rst_cycles) @(posedge sys_clk15);
      n_sys_reset15 <= 1'b1;

      // Idle pins after reset
      repeat (2) @(negedge sys_clk15);
      xfer_errors += check_value("smc_n_cs", 32'(1'b1), 32'(smc_n_cs));
      xfer_errors += check_value("smc_n_we", 32'(1'b1), 32'(smc_n_we));
      xfer_errors += check_value("smc_n_be", 32'(4'hf), 32'(smc_n_be));
      xfer_errors += check_value("ack", 32'(1'b0), 32'(ack));
      xfer_errors += check_value("smc_addr", 32'h0, smc_addr);

      test_name = "bus32_single";
      set_bus(bsiz_32);
      run_transfer(32'h8000_1000, xsiz_32, 32'h1122_3344);
      run_transfer(32'h8000_2002, xsiz_16, 32'ha1b2_c3d4);
      run_transfer(32'h8000_3001, xsiz_8, 32'h5566_7788);
      run_transfer(32'h8000_3003, xsiz_8, 32'h99aa_bbcc);

      test_name = "wide_split";
      set_bus(bsiz_16);
      run_transfer(32'h8000_4000, xsiz_32, 32'hcafe_f00d);
      set_bus(bsiz_8);
      run_transfer(32'h8000_5004, xsiz_32, 32'h0102_0304);

      test_name = "narrow_lanes";                      // Every low address
      for (b = 0; b < 2; b++)
      begin
         set_bus((b == 0) ? bsiz_8 : bsiz_16);
         for (lo = 0; lo < 4; lo++)
         begin
            run_transfer(32'h8000_7000 | 32'(lo), xsiz_16, 32'h8765_4321);
            run_transfer(32'h8000_7100 | 32'(lo), xsiz_8, 32'hf1e2_d3c4);
         end
      end

      test_name = "out_of_window";
      set_bus(bsiz_8);
      run_transfer(32'h1000_0000, xsiz_32, 32'hdead_beef);
      set_bus(bsiz_16);
      run_transfer(32'h4000_0012, xsiz_16, 32'h1357_9bdf);
      set_bus(bsiz_32);
      run_transfer(32'hf000_0003, xsiz_8, 32'h2468_ace0);

      test_name = "random_mix";
      for (k = 0; k < 200; k++)
      begin
         r  = $urandom;
         ra = $urandom;
         set_bus((r[1:0] == 2'b11) ? bsiz_32 : r[1:0]);
         if (r[6:4] != 3'b000)
            ra[31:28] = cs_base;                       // Mostly inside window
         run_transfer(ra, (r[3:2] == 2'b11) ? xsiz_32 : r[3:2], $urandom);
      end

      repeat (2) @(posedge sys_clk15);
      if (exp_q.size() != 0)
      begin
         $display("%0d expected accesses never appeared", exp_q.size());
         proto_errors++;
      end
      $display("Errors: access %0d, transfer %0d, protocol %0d",
               access_errors, xfer_errors, proto_errors);
      if ((access_errors + xfer_errors + proto_errors) == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
